//--- hw/dp_exec_cfg.svh
`ifndef DP_EXEC_CFG_SVH
`define DP_EXEC_CFG_SVH

`define DATA_W     32
`define FLAG_W     4
`define REG_IDX_W  4

// Instruction word fields
`define COND_MSB   31
`define COND_LSB   28
`define IMM_BIT    25
`define OPC_MSB    24
`define OPC_LSB    21
`define S_BIT      20
`define RD_MSB     15
`define RD_LSB     12
`define SHAMT_MSB  11
`define SHAMT_LSB  7
`define SHTYPE_MSB 6
`define SHTYPE_LSB 5
`define ROT_MSB    11
`define ROT_LSB    8
`define IMM8_MSB   7

`endif

//--- hw/dp_exec_pkg.sv
`default_nettype none
`include "dp_exec_cfg.svh"

package dp_exec_pkg;

  // ALU operation codes
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_ADC    = 4'b0001,
    ALU_SUB    = 4'b0010,
    ALU_SBC    = 4'b0011,
    ALU_RSB    = 4'b0100,
    ALU_RSC    = 4'b0101,
    ALU_AND    = 4'b0110,
    ALU_ORR    = 4'b0111,
    ALU_EOR    = 4'b1000,
    ALU_PASS_A = 4'b1001,
    ALU_PASS_B = 4'b1010,
    ALU_MVN    = 4'b1011,
    ALU_BIC    = 4'b1100
  } alu_op_e;

  typedef enum logic [3:0] {
    COND_EQ = 4'h0,
    COND_NE = 4'h1,
    COND_CS = 4'h2,
    COND_CC = 4'h3,
    COND_MI = 4'h4,
    COND_PL = 4'h5,
    COND_VS = 4'h6,
    COND_VC = 4'h7,
    COND_HI = 4'h8,
    COND_LS = 4'h9,
    COND_GE = 4'hA,
    COND_LT = 4'hB,
    COND_GT = 4'hC,
    COND_LE = 4'hD,
    COND_AL = 4'hE,
    COND_NV = 4'hF
  } cond_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c; // Borrow after a subtract
    logic v;
  } flags_t;

  typedef struct packed {
    logic                  valid;
    alu_op_e               op;
    logic                  set_flags;
    cond_e                 cond;
    logic [`REG_IDX_W-1:0] rd;
  } dp_ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
  } operands_t;

  typedef struct packed {
    logic                  valid;
    logic                  executed;
    logic [`REG_IDX_W-1:0] rd;
    logic [`DATA_W-1:0]    result;
    flags_t                flags;
  } exec_out_t;

endpackage

`default_nettype wire

//--- hw/dp_decoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "dp_exec_cfg.svh"

module dp_decoder (
  input  wire logic                 clk,
  input  wire logic                 i_rst_n,
  input  wire logic                 i_valid,
  input  wire logic [`DATA_W-1:0]   i_instr,
  output dp_exec_pkg::dp_ctrl_t     o_ctrl
);

  logic [3:0]            opc;
  dp_exec_pkg::alu_op_e  alu_op;
  dp_exec_pkg::dp_ctrl_t ctrl_d;
  dp_exec_pkg::dp_ctrl_t ctrl_q;

  assign opc = i_instr[`OPC_MSB:`OPC_LSB];

  // Opcode field to ALU operation
  always_comb begin
    case (opc)
      4'b0000: alu_op = dp_exec_pkg::ALU_AND;
      4'b0001: alu_op = dp_exec_pkg::ALU_EOR;
      4'b0010: alu_op = dp_exec_pkg::ALU_SUB;
      4'b0011: alu_op = dp_exec_pkg::ALU_RSB;
      4'b0100: alu_op = dp_exec_pkg::ALU_ADD;
      4'b0101: alu_op = dp_exec_pkg::ALU_ADC;
      4'b0110: alu_op = dp_exec_pkg::ALU_SBC;
      4'b0111: alu_op = dp_exec_pkg::ALU_RSC;
      4'b1100: alu_op = dp_exec_pkg::ALU_ORR;
      4'b1101: alu_op = dp_exec_pkg::ALU_PASS_B; // MOV
      4'b1110: alu_op = dp_exec_pkg::ALU_BIC;
      4'b1111: alu_op = dp_exec_pkg::ALU_MVN;
      // Compare/test group falls back to passing the first operand
      default: alu_op = dp_exec_pkg::ALU_PASS_A;
    endcase
  end

  always_comb begin
    ctrl_d.valid     = i_valid;
    ctrl_d.op        = alu_op;
    ctrl_d.set_flags = i_instr[`S_BIT];
    ctrl_d.cond      = dp_exec_pkg::cond_e'(i_instr[`COND_MSB:`COND_LSB]);
    ctrl_d.rd        = i_instr[`RD_MSB:`RD_LSB];
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q.valid <= ctrl_d.valid;
      if (ctrl_d.valid) begin // Hold fields between instructions
        ctrl_q.op        <= ctrl_d.op;
        ctrl_q.set_flags <= ctrl_d.set_flags;
        ctrl_q.cond      <= ctrl_d.cond;
        ctrl_q.rd        <= ctrl_d.rd;
      end
    end
  end

  assign o_ctrl = ctrl_q;

endmodule

`default_nettype wire

//--- hw/operand_shifter.sv
`timescale 1ns/100ps
`default_nettype none
`include "dp_exec_cfg.svh"

module operand_shifter (
  input  wire logic                 clk,
  input  wire logic                 i_rst_n,
  input  wire logic                 i_valid,
  input  wire logic [`DATA_W-1:0]   i_instr,
  input  wire logic [`DATA_W-1:0]   i_rn_val,
  input  wire logic [`DATA_W-1:0]   i_rm_val,
  output dp_exec_pkg::operands_t    o_operands
);

  localparam int AMT_W = `SHAMT_MSB - `SHAMT_LSB + 1;

  logic [AMT_W-1:0]   shamt;
  logic [1:0]         shtype;
  logic [AMT_W-1:0]   rot_amt;
  logic [`DATA_W-1:0] imm8;
  logic [`DATA_W-1:0] op_b_d;

  logic               valid_q;
  logic [`DATA_W-1:0] op_a_q;
  logic [`DATA_W-1:0] op_b_q;

  // Rotate right where an amount of zero passes the value through
  function automatic logic [`DATA_W-1:0] ror(input logic [`DATA_W-1:0] val,
                                             input logic [AMT_W-1:0]   amt);
    if (amt == '0)
      ror = val;
    else
      ror = (val >> amt) | (val << (`DATA_W - amt));
  endfunction

  assign shamt   = i_instr[`SHAMT_MSB:`SHAMT_LSB];
  assign shtype  = i_instr[`SHTYPE_MSB:`SHTYPE_LSB];
  assign rot_amt = {i_instr[`ROT_MSB:`ROT_LSB], 1'b0}; // Twice the rotate field
  assign imm8    = {{(`DATA_W - `IMM8_MSB - 1){1'b0}}, i_instr[`IMM8_MSB:0]};

  always_comb begin
    if (i_instr[`IMM_BIT]) begin
      op_b_d = ror(imm8, rot_amt);
    end else begin
      case (shtype)
        2'b00:   op_b_d = i_rm_val << shamt;           // LSL
        2'b01:   op_b_d = i_rm_val >> shamt;           // LSR
        2'b10:   op_b_d = $signed(i_rm_val) >>> shamt; // ASR
        default: op_b_d = ror(i_rm_val, shamt);
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= i_valid;
  end

  // Operand data
  always_ff @(posedge clk) begin
    if (i_valid) begin
      op_a_q <= i_rn_val;
      op_b_q <= op_b_d;
    end
  end

  always_comb begin
    o_operands.valid = valid_q;
    o_operands.op_a  = op_a_q;
    o_operands.op_b  = op_b_q;
  end

endmodule

`default_nettype wire

//--- hw/alu_flags_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "dp_exec_cfg.svh"

module alu_flags_stage (
  input  wire logic                      clk,
  input  wire logic                      i_rst_n,
  input  wire dp_exec_pkg::dp_ctrl_t     i_ctrl,
  input  wire dp_exec_pkg::operands_t    i_operands,
  output dp_exec_pkg::exec_out_t         o_out
);

  dp_exec_pkg::flags_t   flags_q;
  dp_exec_pkg::flags_t   flags_d;
  logic                  in_valid; // Both stage-one halves hold an instruction
  logic                  cond_ok;
  logic                  do_exec;

  logic [`DATA_W-1:0]    a;
  logic [`DATA_W-1:0]    b;
  logic                  reverse;  // RSB/RSC swap the subtract operands
  logic                  add_cin;
  logic                  sub_cin;
  logic [`DATA_W-1:0]    sub_x;
  logic [`DATA_W-1:0]    sub_y;
  logic [`DATA_W:0]      sum_w;
  logic [`DATA_W:0]      diff_w;
  logic [`DATA_W-1:0]    result;
  logic                  c_new;
  logic                  v_new;

  logic                  valid_q;
  logic                  executed_q;
  logic [`REG_IDX_W-1:0] rd_q;
  logic [`DATA_W-1:0]    result_q;

  // Condition check against stored flags
  always_comb begin
    case (i_ctrl.cond)
      dp_exec_pkg::COND_EQ: cond_ok = flags_q.z;
      dp_exec_pkg::COND_NE: cond_ok = ~flags_q.z;
      dp_exec_pkg::COND_CS: cond_ok = flags_q.c;
      dp_exec_pkg::COND_CC: cond_ok = ~flags_q.c;
      dp_exec_pkg::COND_MI: cond_ok = flags_q.n;
      dp_exec_pkg::COND_PL: cond_ok = ~flags_q.n;
      dp_exec_pkg::COND_VS: cond_ok = flags_q.v;
      dp_exec_pkg::COND_VC: cond_ok = ~flags_q.v;
      dp_exec_pkg::COND_HI: cond_ok = flags_q.c & ~flags_q.z;
      dp_exec_pkg::COND_LS: cond_ok = ~flags_q.c | flags_q.z;
      dp_exec_pkg::COND_GE: cond_ok = (flags_q.n == flags_q.v);
      dp_exec_pkg::COND_LT: cond_ok = (flags_q.n != flags_q.v);
      dp_exec_pkg::COND_GT: cond_ok = ~flags_q.z & (flags_q.n == flags_q.v);
      dp_exec_pkg::COND_LE: cond_ok = flags_q.z | (flags_q.n != flags_q.v);
      dp_exec_pkg::COND_AL: cond_ok = 1'b1;
      default:              cond_ok = 1'b0; // NV
    endcase
  end

  assign in_valid = i_ctrl.valid & i_operands.valid;
  assign do_exec  = in_valid & cond_ok;

  assign a = i_operands.op_a;
  assign b = i_operands.op_b;

  assign reverse = (i_ctrl.op == dp_exec_pkg::ALU_RSB) || (i_ctrl.op == dp_exec_pkg::ALU_RSC);
  assign add_cin = (i_ctrl.op == dp_exec_pkg::ALU_ADC) & flags_q.c;
  assign sub_cin = ((i_ctrl.op == dp_exec_pkg::ALU_SBC) || (i_ctrl.op == dp_exec_pkg::ALU_RSC))
                   & flags_q.c;
  assign sub_x   = reverse ? b : a;
  assign sub_y   = reverse ? a : b;

  // Adder and subtractor with carry or borrow in the top bit
  assign sum_w  = {1'b0, a} + {1'b0, b} + add_cin;
  assign diff_w = {1'b0, sub_x} - {1'b0, sub_y} - sub_cin;

  always_comb begin
    c_new = 1'b0;
    v_new = 1'b0;
    case (i_ctrl.op)
      dp_exec_pkg::ALU_ADD,
      dp_exec_pkg::ALU_ADC: begin
        result = sum_w[`DATA_W-1:0];
        c_new  = sum_w[`DATA_W];
        v_new  = ~(a[`DATA_W-1] ^ b[`DATA_W-1]) & (a[`DATA_W-1] ^ result[`DATA_W-1]);
      end
      dp_exec_pkg::ALU_SUB,
      dp_exec_pkg::ALU_SBC,
      dp_exec_pkg::ALU_RSB,
      dp_exec_pkg::ALU_RSC: begin
        result = diff_w[`DATA_W-1:0];
        c_new  = diff_w[`DATA_W]; // Borrow out
        v_new  = (sub_x[`DATA_W-1] ^ sub_y[`DATA_W-1]) &
                 (sub_x[`DATA_W-1] ^ result[`DATA_W-1]);
      end
      dp_exec_pkg::ALU_AND:    result = a & b;
      dp_exec_pkg::ALU_ORR:    result = a | b;
      dp_exec_pkg::ALU_EOR:    result = a ^ b;
      dp_exec_pkg::ALU_PASS_B: result = b;
      dp_exec_pkg::ALU_MVN:    result = ~b;
      dp_exec_pkg::ALU_BIC:    result = a & ~b;
      default:                 result = a;
    endcase
  end

  always_comb begin
    flags_d.n = result[`DATA_W-1];
    flags_d.z = (result == '0);
    flags_d.c = c_new;
    flags_d.v = v_new;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      valid_q    <= 1'b0;
      executed_q <= 1'b0;
      flags_q    <= dp_exec_pkg::flags_t'({`FLAG_W{1'b0}});
    end else begin
      valid_q    <= in_valid;
      executed_q <= do_exec;
      if (do_exec && i_ctrl.set_flags)
        flags_q <= flags_d;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (do_exec) begin
      rd_q     <= i_ctrl.rd;
      result_q <= result;
    end
  end

  always_comb begin
    o_out.valid    = valid_q;
    o_out.executed = executed_q;
    o_out.rd       = rd_q;
    o_out.result   = result_q;
    o_out.flags    = flags_q; // Flags as left by this instruction
  end

endmodule

`default_nettype wire

//--- hw/dp_exec_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "dp_exec_cfg.svh"

module dp_exec_top (
  input  wire logic                   clk,
  input  wire logic                   i_rst_n,
  input  wire logic                   i_valid,
  input  wire logic [`DATA_W-1:0]     i_instr,
  input  wire logic [`DATA_W-1:0]     i_rn_val,
  input  wire logic [`DATA_W-1:0]     i_rm_val,
  output logic                        o_valid,
  output logic                        o_executed,
  output logic [`REG_IDX_W-1:0]       o_rd,
  output logic [`DATA_W-1:0]          o_result,
  output dp_exec_pkg::flags_t         o_flags
);

  dp_exec_pkg::dp_ctrl_t  ctrl;
  dp_exec_pkg::operands_t operands;
  dp_exec_pkg::exec_out_t exec_out;

  // Stage one, decode and operand forming in parallel
  dp_decoder u_decoder (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_instr (i_instr),
    .o_ctrl  (ctrl)
  );

  operand_shifter u_shifter (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_instr    (i_instr),
    .i_rn_val   (i_rn_val),
    .i_rm_val   (i_rm_val),
    .o_operands (operands)
  );

  // Stage two
  alu_flags_stage u_alu (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_ctrl     (ctrl),
    .i_operands (operands),
    .o_out      (exec_out)
  );

  assign o_valid    = exec_out.valid;
  assign o_executed = exec_out.executed;
  assign o_rd       = exec_out.rd;
  assign o_result   = exec_out.result;
  assign o_flags    = exec_out.flags;

endmodule

`default_nettype wire

//--- verification/dp_exec_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "dp_exec_cfg.svh"

module dp_exec_checker #(
  parameter int NUM_TESTS = 1
) (
  input  wire logic                   clk,
  input  wire logic                   i_rst_n,
  input  wire logic                   i_issue,
  input  wire dp_exec_pkg::exec_out_t i_exp,
  input  wire dp_exec_pkg::exec_out_t i_obs,
  output logic                        o_done,
  output logic                        o_timeout,
  output int                          o_pass_count,
  output int                          o_fail_count
);

  localparam int CYCLE_LIMIT = 2 * NUM_TESTS + 50;

  dp_exec_pkg::exec_out_t exp_q [$]; // Issued but not yet retired
  dp_exec_pkg::exec_out_t want;
  int                     checked = 0;
  int                     cycles = 0;
  int                     pass_n = 0;
  int                     fail_n = 0;
  logic                   reset_seen = 1'b0;
  logic                   reset_checked = 1'b0;
  logic                   match;

  assign o_done       = (checked == NUM_TESTS);
  assign o_timeout    = (cycles >= CYCLE_LIMIT);
  assign o_pass_count = pass_n;
  assign o_fail_count = fail_n;

  always @(posedge clk)
    cycles <= cycles + 1;

  // Sample on the falling edge where outputs have settled
  always @(negedge clk) begin
    if (!i_rst_n) begin
      reset_seen = 1'b1;
    end else if (reset_seen && !reset_checked) begin
      reset_checked = 1'b1; // First cycle out of reset
      if (i_obs.valid !== 1'b0 || i_obs.flags !== '0) begin
        fail_n++;
        $display("error at time %0t: reset state wrong, valid %0b flags %b",
                 $time, i_obs.valid, i_obs.flags);
      end else begin
        $display("reset state: ok");
      end
    end
    if (i_rst_n && i_issue)
      exp_q.push_back(i_exp);
    if (i_rst_n && i_obs.valid) begin
      if (exp_q.size() == 0) begin
        fail_n++;
        $display("Unexpected output at time %0t with no instruction in flight", $time);
      end else begin
        want  = exp_q.pop_front();
        match = (i_obs.executed == want.executed) && (i_obs.flags == want.flags);
        if (want.executed) // Result and rd hold when skipped
          match = match && (i_obs.rd == want.rd) && (i_obs.result == want.result);
        if (match) begin
          pass_n++;
          $display("test %0d: ok", checked);
        end else begin
          fail_n++;
          $display("error at time %0t: test %0d expected exec %0b rd %0d result %h flags %b",
                   $time, checked, want.executed, want.rd, want.result, want.flags);
          $display("  got exec %0b rd %0d result %h flags %b",
                   i_obs.executed, i_obs.rd, i_obs.result, i_obs.flags);
        end
        checked++;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/dp_exec_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "dp_exec_cfg.svh"

module dp_exec_tb;

  localparam int NUM_TESTS = 160;

  logic                   clk = 1'b0;
  logic                   i_rst_n;
  logic                   i_valid;
  logic [`DATA_W-1:0]     i_instr;
  logic [`DATA_W-1:0]     i_rn_val;
  logic [`DATA_W-1:0]     i_rm_val;
  logic                   o_valid;
  logic                   o_executed;
  logic [`REG_IDX_W-1:0]  o_rd;
  logic [`DATA_W-1:0]     o_result;
  dp_exec_pkg::flags_t    o_flags;
  dp_exec_pkg::exec_out_t expected;
  dp_exec_pkg::exec_out_t observed;
  logic                   done;
  logic                   timed_out;
  int                     pass_count;
  int                     fail_count;

  // Stimulus and expected table
  logic [31:0]            tbl_instr [NUM_TESTS];
  logic [31:0]            tbl_rn [NUM_TESTS];
  logic [31:0]            tbl_rm [NUM_TESTS];
  dp_exec_pkg::exec_out_t tbl_exp [NUM_TESTS];
  int                     n_fill = 0;
  dp_exec_pkg::flags_t    model_flags = '0; // Reference flags, carried entry to entry
  logic [31:0]            lfsr_state = 32'h5526802a;
  logic [31:0]            rnd [3];

  always #2 clk = ~clk;

  dp_exec_top dut0 (.*);

  assign observed = {o_valid, o_executed, o_rd, o_result, o_flags};

  dp_exec_checker #(.NUM_TESTS(NUM_TESTS)) chk0 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_issue      (i_valid),
    .i_exp        (expected),
    .i_obs        (observed),
    .o_done       (done),
    .o_timeout    (timed_out),
    .o_pass_count (pass_count),
    .o_fail_count (fail_count)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[31]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [31:0] rotr(input logic [31:0] v, input logic [4:0] amt);
    logic [63:0] both;
    both = {v, v} >> amt;
    return both[31:0];
  endfunction

  function automatic logic [31:0] form_op_b(input logic [31:0] instr, input logic [31:0] rm);
    logic [4:0] amt;
    amt = instr[11:7];
    if (instr[25]) begin
      return rotr({24'd0, instr[7:0]}, {instr[11:8], 1'b0});
    end else begin
      case (instr[6:5])
        2'b00:   return rm << amt;
        2'b01:   return rm >> amt;
        2'b10:   return $unsigned($signed(rm) >>> amt);
        default: return rotr(rm, amt);
      endcase
    end
  endfunction

  // Odd codes invert the even one, so AL/NV fall out too
  function automatic logic cond_holds(input logic [3:0] cond, input dp_exec_pkg::flags_t f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = 1'b1;
    endcase
    return base ^ cond[0];
  endfunction

  function automatic logic [31:0] dp_imm(input logic [3:0] cond, input logic [3:0] opc,
                                         input logic s, input logic [3:0] rd,
                                         input logic [3:0] rot, input logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, opc, s, 4'h0, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] dp_reg(input logic [3:0] cond, input logic [3:0] opc,
                                         input logic s, input logic [3:0] rd,
                                         input logic [4:0] shamt, input logic [1:0] shtype);
    return {cond, 2'b00, 1'b0, opc, s, 4'h0, rd, shamt, shtype, 1'b0, 4'h2};
  endfunction

  task automatic add_entry(input logic [31:0] instr, input logic [31:0] rn,
                           input logic [31:0] rm);
    logic [3:0]  opc;
    logic [31:0] b;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    logic [33:0] ext; // Exact signed value
    logic        cin;
    logic        c;
    logic        run;
    opc = instr[24:21];
    b   = form_op_b(instr, rm);
    cin = (opc == 4'h5 || opc == 4'h6 || opc == 4'h7) ? model_flags.c : 1'b0;
    x   = (opc == 4'h3 || opc == 4'h7) ? b : rn; // Reverse subtracts
    y   = (opc == 4'h3 || opc == 4'h7) ? rn : b;
    c   = 1'b0;
    ext = '0;
    case (opc)
      4'h0: r = rn & b;
      4'h1: r = rn ^ b;
      4'h4, 4'h5: begin
        {c, r} = {1'b0, rn} + {1'b0, b} + {32'd0, cin};
        ext    = {{2{rn[31]}}, rn} + {{2{b[31]}}, b} + {33'd0, cin};
      end
      4'h2, 4'h3, 4'h6, 4'h7: begin
        r   = x - y - {31'd0, cin};
        c   = ({1'b0, x} < ({1'b0, y} + {32'd0, cin})); // Borrow
        ext = {{2{x[31]}}, x} - {{2{y[31]}}, y} - {33'd0, cin};
      end
      4'hC:    r = rn | b;
      4'hD:    r = b;
      4'hE:    r = rn & ~b;
      4'hF:    r = ~b;
      default: r = rn; // Test and compare rows pass the first operand
    endcase
    run = cond_holds(instr[31:28], model_flags);
    if (run && instr[20]) begin
      model_flags.n = r[31];
      model_flags.z = (r == 32'd0);
      model_flags.c = c;
      model_flags.v = (ext[33:31] != 3'b000) && (ext[33:31] != 3'b111);
    end
    tbl_instr[n_fill] = instr;
    tbl_rn[n_fill]    = rn;
    tbl_rm[n_fill]    = rm;
    tbl_exp[n_fill]   = {1'b1, run, instr[15:12], r, model_flags};
    n_fill++;
  endtask

  initial begin
    i_rst_n  = 1'b0;
    i_valid  = 1'b0;
    i_instr  = '0;
    i_rn_val = '0;
    i_rm_val = '0;
    expected = '0;
    add_entry(dp_imm(4'hE, 4'hD, 1'b1, 4'd1, 4'd0, 8'h00), 32'd0, 32'd0); // MOVS #0
    add_entry(dp_imm(4'hE, 4'h4, 1'b1, 4'd2, 4'd0, 8'h01), 32'h7FFF_FFFF, 32'd0);
    add_entry(dp_reg(4'hE, 4'h4, 1'b1, 4'd3, 5'd0, 2'b00), 32'hFFFF_FFFF, 32'd1);
    add_entry(dp_reg(4'hE, 4'h5, 1'b1, 4'd4, 5'd0, 2'b00), 32'd5, 32'd3);  // ADCS, C set
    add_entry(dp_reg(4'hE, 4'h2, 1'b1, 4'd5, 5'd0, 2'b00), 32'd3, 32'd5);  // Borrow
    add_entry(dp_reg(4'hE, 4'h6, 1'b1, 4'd6, 5'd0, 2'b00), 32'd10, 32'd3); // SBCS, C set
    add_entry(dp_reg(4'hE, 4'h5, 1'b1, 4'd7, 5'd0, 2'b00), 32'd5, 32'd3);  // ADCS, C clear
    add_entry(dp_imm(4'hE, 4'h7, 1'b1, 4'd8, 4'd0, 8'h04), 32'd9, 32'd0);
    add_entry(dp_reg(4'hE, 4'h6, 1'b1, 4'd9, 5'd0, 2'b00), 32'd10, 32'd3);
    add_entry(dp_imm(4'hE, 4'h4, 1'b0, 4'd10, 4'd0, 8'h00), 32'd0, 32'd0); // Zero, no S
    for (int op = 0; op < 16; op++) begin
      add_entry(dp_reg(4'hE, op[3:0], 1'b1, op[3:0], 5'd4, 2'b00), 32'hF0F0_1234,
                32'h8FF0_8001);
      add_entry(dp_imm(4'hE, op[3:0], 1'b1, op[3:0], 4'd1, 8'hC3), 32'h8000_0007, 32'd0);
    end
    for (int sh = 0; sh < 16; sh++) // Amounts 0, 9, 18, 27 per shift type
      add_entry(dp_reg(4'hE, 4'hD, 1'b0, 4'd3, 5'(9 * (sh % 4)), sh[3:2]), 32'd0,
                32'h8421_F00D);
    for (int rot = 0; rot < 16; rot++)
      add_entry(dp_imm(4'hE, 4'hD, 1'b1, 4'd4, rot[3:0], 8'hA5), 32'd0, 32'd0);
    add_entry(dp_imm(4'hE, 4'hD, 1'b1, 4'd0, 4'd0, 8'h00), 32'd0, 32'd0);
    for (int cc = 0; cc < 16; cc++)
      add_entry(dp_imm(cc[3:0], 4'hD, 1'b0, 4'd1, 4'd0, 8'(cc)), 32'd0, 32'd0);
    add_entry(dp_reg(4'hE, 4'h2, 1'b1, 4'd0, 5'd0, 2'b00), 32'h8000_0000, 32'd1); // Sets V
    for (int cc = 0; cc < 16; cc++)
      add_entry(dp_imm(cc[3:0], 4'h4, 1'b1, 4'd2, 4'd0, 8'(cc)), 32'hFFFF_FFF8, 32'd0);
    while (n_fill < NUM_TESTS) begin
      draw_bits(32, rnd[0]);
      draw_bits(32, rnd[1]);
      draw_bits(32, rnd[2]);
      rnd[0][27:26] = 2'b00; // Data-processing group only
      add_entry(rnd[0], rnd[1], rnd[2]);
    end
    repeat (4) @(posedge clk);
    #1 i_rst_n = 1'b1;
    for (int k = 0; k < NUM_TESTS; k++) begin
      @(posedge clk);
      #1;
      i_valid  = 1'b1;
      i_instr  = tbl_instr[k];
      i_rn_val = tbl_rn[k];
      i_rm_val = tbl_rm[k];
      expected = tbl_exp[k];
    end
    @(posedge clk);
    #1 i_valid = 1'b0;
  end

  initial begin
    wait (done || timed_out);
    $display("Tests: %0d passed, %0d failed, %0d in table", pass_count, fail_count, NUM_TESTS);
    if (!timed_out && fail_count == 0) begin
      $display("Regression passed");
    end else begin
      if (timed_out)
        $display("Timeout: results still missing at the cycle limit");
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/dp_exec_pkg.sv
hw/dp_decoder.sv
hw/operand_shifter.sv
hw/alu_flags_stage.sv
hw/dp_exec_top.sv
verification/dp_exec_checker.sv
verification/dp_exec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module dp_exec_tb \
  -f project.f --Mdir obj_dir -o dp_exec_sim

./obj_dir/dp_exec_sim | tee sim.log

if grep -qx "Regression passed" sim.log; then
  exit 0
fi
exit 1
